/* include/soqpsk_settings.svh */
`ifndef SOQPSK_SETTINGS_SVH
`define SOQPSK_SETTINGS_SVH

// Clocks per symbol, also the CIC interpolation ratio.
`define SOQPSK_INTERP 8
// Impulse magnitude for a +1 or -1 symbol.
`define SOQPSK_LEVEL 16384
// Arithmetic right shift in the output scaler.
`define SOQPSK_CIC_SHIFT 6
`define SOQPSK_SAMPLE_W 18
`define SOQPSK_CIC_W 34

`endif

/* hw/soqpskPkg.sv */
`include "soqpsk_settings.svh"

package soqpskPkg;

   // ======================================================================
   // Ternary symbol of the SOQPSK-TG precoder
   // ======================================================================
   // Encoded as a 2-bit two's complement value.
   typedef enum logic [1:0] {
      symZero  = 2'b00,
      symPlus  = 2'b01,
      symMinus = 2'b11
   } symbol_t;

   // ======================================================================
   // Precoder output
   // ======================================================================
   typedef struct packed {
      symbol_t                            sym;
      logic signed [`SOQPSK_SAMPLE_W-1:0] impulse;   // +LEVEL, 0 or -LEVEL.
   } precodeOut_t;

endpackage

/* hw/dspPkg.sv */
`include "soqpsk_settings.svh"

package dspPkg;

   // ======================================================================
   // Fixed-point sample types
   // ======================================================================
   typedef logic signed [`SOQPSK_SAMPLE_W-1:0] sample_t;

   // Integrator word of the CIC, wraps on overflow.
   typedef logic signed [`SOQPSK_CIC_W-1:0] cicWord_t;

   // Frequency word handed to the NCO.
   typedef struct packed {
      sample_t freq;
      logic    sat;   // Set when the scaler clamped.
   } freqWord_t;

endpackage

/* hw/symbolTimer.sv */
`timescale 1ns/1ps
`include "soqpsk_settings.svh"

module symbolTimer (
   input  logic clk,
   input  logic reset,
   output logic symEn,
   output logic combEn
);

   localparam int COUNT_W = $clog2(`SOQPSK_INTERP);
   localparam logic [COUNT_W-1:0] LAST = COUNT_W'(`SOQPSK_INTERP - 1);
   localparam logic [COUNT_W-1:0] PRE_LAST = COUNT_W'(`SOQPSK_INTERP - 2);

   logic [COUNT_W-1:0] count;

   // symEn is high while count sits at LAST.
   always_ff @(posedge clk) begin
      if (reset) begin
         count  <= '0;
         symEn  <= 1'b0;
         combEn <= 1'b0;
      end else begin
         count  <= (count == LAST) ? '0 : count + 1'b1;
         symEn  <= (count == PRE_LAST);
         combEn <= symEn;   // Comb sees the freshly registered symbol.
      end
   end

endmodule

/* hw/soqpskPrecoder.sv */
`timescale 1ns/1ps
`include "soqpsk_settings.svh"

module soqpskPrecoder (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   symEn,
   input  logic                   dataBit,
   output soqpskPkg::precodeOut_t precode
);

   import soqpskPkg::*;

   localparam int SW = `SOQPSK_SAMPLE_W;
   localparam logic signed [SW-1:0] LEVEL_POS = SW'(`SOQPSK_LEVEL);
   localparam logic signed [SW-1:0] LEVEL_NEG = -LEVEL_POS;

   logic        aPrev1;   // a(k-1), 1 means +1.
   logic        aPrev2;   // a(k-2).
   logic        oddSym;   // Parity of k.
   logic        bitChanged;
   logic        isPlus;
   precodeOut_t nextOut;

   // alpha = (-1)^(k+1) * a(k-1) * (a(k) - a(k-2)) / 2.
   always_comb begin
      bitChanged = dataBit ^ aPrev2;
      isPlus     = dataBit ^ aPrev1 ^ oddSym;
      if (!bitChanged) begin
         nextOut = '{sym: symZero, impulse: '0};
      end else if (isPlus) begin
         nextOut = '{sym: symPlus, impulse: LEVEL_POS};
      end else begin
         nextOut = '{sym: symMinus, impulse: LEVEL_NEG};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         aPrev1  <= 1'b1;   // History starts at +1.
         aPrev2  <= 1'b1;
         oddSym  <= 1'b0;
         precode <= '{sym: symZero, impulse: '0};
      end else if (symEn) begin
         aPrev1  <= dataBit;
         aPrev2  <= aPrev1;
         oddSym  <= ~oddSym;
         precode <= nextOut;
      end
   end

endmodule

/* hw/cicInterpolate.sv */
`timescale 1ns/1ps
`include "soqpsk_settings.svh"

module cicInterpolate (
   input  logic             clk,
   input  logic             reset,
   input  logic             clkEn,
   input  dspPkg::sample_t  dIn,
   output dspPkg::cicWord_t dOut
);

   import dspPkg::*;

   localparam int SW = `SOQPSK_SAMPLE_W;
   localparam int TW = SW + 2;
   localparam int CW = `SOQPSK_CIC_W;

   // ======================================================================
   // Comb, (1 - z)^3 = 1 - 3z + 3z^2 - z^3 in FIR form
   // ======================================================================
   logic signed [TW-1:0] xExt;
   logic signed [TW-1:0] x3;
   logic signed [TW-1:0] tap0;
   logic signed [TW-1:0] tap1;
   logic signed [TW-1:0] tap2;
   logic signed [TW-1:0] tap3;

   assign xExt = {{2{dIn[SW-1]}}, dIn};
   assign x3   = xExt + (xExt <<< 1);

   always_ff @(posedge clk) begin
      if (reset) begin
         tap0 <= '0;
         tap1 <= '0;
         tap2 <= '0;
         tap3 <= '0;
      end else if (clkEn) begin
         tap0 <= xExt;
         tap1 <= x3 - tap0;
         tap2 <= tap1 - x3;
         tap3 <= tap2 + xExt;
      end else begin
         tap3 <= '0;   // Zero stuffing.
      end
   end

   // ======================================================================
   // Integrators, every clock
   // ======================================================================
   cicWord_t combExt;
   cicWord_t acc0;
   cicWord_t acc1;
   cicWord_t acc2;

   assign combExt = {{(CW - TW){tap3[TW-1]}}, tap3};

   always_ff @(posedge clk) begin
      if (reset) begin
         acc0 <= '0;
         acc1 <= '0;
         acc2 <= '0;
      end else begin
         acc0 <= acc0 + combExt;
         acc1 <= acc1 + acc0;
         acc2 <= acc2 + acc1;
      end
   end

   assign dOut = acc2;

endmodule

/* hw/freqScaler.sv */
`timescale 1ns/1ps
`include "soqpsk_settings.svh"

module freqScaler (
   input  logic              clk,
   input  logic              reset,
   input  dspPkg::cicWord_t  acc,
   output dspPkg::freqWord_t freqOut
);

   import dspPkg::*;

   localparam int SW = `SOQPSK_SAMPLE_W;
   localparam int CW = `SOQPSK_CIC_W;
   localparam int SHIFT = `SOQPSK_CIC_SHIFT;
   localparam cicWord_t ROUND = cicWord_t'(1) <<< (SHIFT - 1);
   localparam sample_t MAX_VAL = {1'b0, {(SW - 1){1'b1}}};
   localparam sample_t MIN_VAL = {1'b1, {(SW - 1){1'b0}}};

   cicWord_t       rounded;
   cicWord_t       shifted;
   logic [CW-SW:0] topBits;
   logic           overflow;
   freqWord_t      nextOut;

   always_comb begin
      rounded  = acc + ROUND;   // Round half up.
      shifted  = rounded >>> SHIFT;
      topBits  = shifted[CW-1:SW-1];
      overflow = !((&topBits) || !(|topBits));   // Fits only if all sign bits agree.
      nextOut.sat  = overflow;
      nextOut.freq = overflow ? (shifted[CW-1] ? MIN_VAL : MAX_VAL) : shifted[SW-1:0];
   end

   always_ff @(posedge clk) begin
      if (reset) freqOut <= '0;
      else       freqOut <= nextOut;
   end

endmodule

/* hw/soqpskFreqPulse.sv */
`timescale 1ns/1ps

module soqpskFreqPulse (
   input  logic              clk,
   input  logic              reset,
   input  logic              dataBit,
   output logic              symEn,
   output soqpskPkg::symbol_t symOut,
   output dspPkg::freqWord_t freqOut
);

   import soqpskPkg::*;
   import dspPkg::*;

   logic        combEn;
   precodeOut_t precode;
   cicWord_t    cicOut;

   // ======================================================================
   // Symbol timing and precoding
   // ======================================================================
   symbolTimer uTimer (
      .clk    (clk),
      .reset  (reset),
      .symEn  (symEn),
      .combEn (combEn)
   );

   soqpskPrecoder uPrecoder (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .dataBit (dataBit),
      .precode (precode)
   );

   assign symOut = precode.sym;   // To timing recovery or framing.

   // ======================================================================
   // Pulse shaping
   // ======================================================================
   cicInterpolate uCic (
      .clk   (clk),
      .reset (reset),
      .clkEn (combEn),
      .dIn   (precode.impulse),
      .dOut  (cicOut)
   );

   freqScaler uScaler (
      .clk     (clk),
      .reset   (reset),
      .acc     (cicOut),
      .freqOut (freqOut)
   );

endmodule

/* verif/freqPulseChecker.sv */
`timescale 1ns/1ps
`include "soqpsk_settings.svh"

module freqPulseChecker (
   input  logic               clk,
   input  logic               reset,
   input  logic               symEn,
   input  soqpskPkg::symbol_t symOut,
   input  dspPkg::freqWord_t  freqOut,
   input  soqpskPkg::symbol_t expSym,
   output int                 resetErrs,
   output int                 strobeErrs,
   output int                 symErrs,
   output int                 shapeErrs,
   output int                 runErrs
);

   import soqpskPkg::*;
   import dspPkg::*;

   localparam int     SHIFT = `SOQPSK_CIC_SHIFT;
   localparam int     LEVEL = `SOQPSK_LEVEL;
   localparam longint MAX_F = (longint'(1) <<< (`SOQPSK_SAMPLE_W - 1)) - 1;
   localparam longint MIN_F = -(longint'(1) <<< (`SOQPSK_SAMPLE_W - 1));
   // Steady output of a run of equal symbols, CIC DC gain is INTERP^2.
   localparam longint RUN_BOUND =
      (longint'(LEVEL) * `SOQPSK_INTERP * `SOQPSK_INTERP + (longint'(1) <<< (SHIFT - 1)))
      >>> SHIFT;

   int resetCount  = 0;
   int strobeCount = 0;
   int symCount    = 0;
   int shapeCount  = 0;
   int runCount    = 0;

   assign resetErrs  = resetCount;
   assign strobeErrs = strobeCount;
   assign symErrs    = symCount;
   assign shapeErrs  = shapeCount;
   assign runErrs    = runCount;

   // Inputs as they stood before the last rising edge.
   logic    pReset  = 1'b1;
   logic    pSymEn  = 1'b0;
   symbol_t pExpSym = symZero;
   symbol_t lastSym = symZero;
   int      sinceStrobe = 0;
   int      resetAge = 0;
   int      zeroSyms = 0;
   int      sameRun  = 0;

   // Model of the shaping path, one variable per register.
   int        mImp = 0;
   int        mH1 = 0;
   int        mH2 = 0;
   int        mH3 = 0;
   int        mComb = 0;
   logic      mCombEn = 1'b0;
   cicWord_t  mAcc0 = '0;
   cicWord_t  mAcc1 = '0;
   cicWord_t  mAcc2 = '0;
   freqWord_t mOut = '0;

   function automatic int levelOf(input symbol_t s);
      if (s == symPlus) return LEVEL;
      if (s == symMinus) return -LEVEL;
      return 0;
   endfunction

   // Round half up, shift, clamp to the sample range.
   function automatic freqWord_t scaleModel(input cicWord_t acc);
      longint    v;
      freqWord_t r;
      v = (longint'(acc) + (longint'(1) <<< (SHIFT - 1))) >>> SHIFT;
      r.sat = (v > MAX_F) || (v < MIN_F);
      if (v > MAX_F) r.freq = sample_t'(MAX_F);
      else if (v < MIN_F) r.freq = sample_t'(MIN_F);
      else r.freq = sample_t'(v);
      return r;
   endfunction

   task automatic reportMismatch(input string test, input longint expVal, input longint actVal);
      $display("error: %s expected %0d actual %0d", test, expVal, actVal);
   endtask

   always @(negedge clk) begin
      longint fv;
      if (pReset) begin
         {mImp, mH1, mH2, mH3, mComb} = '0;
         mCombEn = 1'b0;
         {mAcc0, mAcc1, mAcc2} = '0;
         mOut = '0;
         sinceStrobe = 1;   // First strobe lands INTERP-1 clocks after reset.
         resetAge = 0;
         {zeroSyms, sameRun} = '0;
         lastSym = symZero;
      end else begin
         // Last stage first, so every register sees its old input.
         mOut  = scaleModel(mAcc2);
         mAcc2 = mAcc2 + mAcc1;
         mAcc1 = mAcc1 + mAcc0;
         mAcc0 = mAcc0 + cicWord_t'(mComb);
         if (mCombEn) begin
            mComb = mImp - 3 * mH1 + 3 * mH2 - mH3;
            mH3 = mH2;
            mH2 = mH1;
            mH1 = mImp;
         end else begin
            mComb = 0;   // Zero stuffing.
         end
         if (pSymEn) mImp = levelOf(pExpSym);
         mCombEn = pSymEn;
         if (resetAge < 2) resetAge++;

         sinceStrobe++;
         if (symEn) begin
            if (sinceStrobe != `SOQPSK_INTERP) begin
               strobeCount++;
               reportMismatch("strobe spacing", `SOQPSK_INTERP, sinceStrobe);
            end
            sinceStrobe = 0;
         end else if (sinceStrobe == `SOQPSK_INTERP + 1) begin
            strobeCount++;
            $display("symEn missing where a strobe was due");
         end

         if (pSymEn) begin
            if (symOut !== pExpSym) begin
               symCount++;
               $display("error: precoder symbol expected %s actual %s (%b)",
                        pExpSym.name(), symOut.name(), symOut);
            end
            if (pExpSym == symZero) begin
               zeroSyms++;
               sameRun = 0;
            end else begin
               zeroSyms = 0;
               sameRun  = (pExpSym == lastSym) ? sameRun + 1 : 1;
            end
            lastSym = pExpSym;
         end
      end

      if (resetAge <= 1) begin
         if (symEn !== 1'b0 || symOut !== symZero) begin
            resetCount++;
            reportMismatch("reset symEn and symOut", 0, {symEn, symOut});
         end
         if (freqOut !== '0) begin
            resetCount++;
            reportMismatch("reset freqOut", 0, freqOut);
         end
      end

      if (freqOut.freq !== mOut.freq) begin
         shapeCount++;
         reportMismatch("pulse shape freq", mOut.freq, freqOut.freq);
      end
      if (freqOut.sat !== mOut.sat) begin
         shapeCount++;
         reportMismatch("pulse shape sat", mOut.sat, freqOut.sat);
      end

      fv = longint'(freqOut.freq);
      if (zeroSyms >= 4 && fv != 0) begin
         runCount++;
         reportMismatch("constant run settle", 0, fv);
      end
      if (sameRun >= 4) begin
         if (fv == 0 || fv > RUN_BOUND || fv < -RUN_BOUND || freqOut.sat) begin
            runCount++;
            $display("error: nonzero run expected 0 < |freq| <= %0d, sat 0 actual %0d, sat %b",
                     RUN_BOUND, fv, freqOut.sat);
         end
      end

      pReset  = reset;
      pSymEn  = symEn;
      pExpSym = expSym;
   end

endmodule

/* verif/tbSoqpskFreqPulse.sv */
`timescale 1ns/1ps
`include "soqpsk_settings.svh"

module tbSoqpskFreqPulse;

   import soqpskPkg::*;
   import dspPkg::*;

   localparam int NUM_PAT = 34;
   localparam int CLK_HALF = 4;                          // 8 ns period.
   localparam int DRIVE_DELAY = 1;
   localparam int RESET_CYCLES = 5;
   localparam int STROBE_TIMEOUT = 4 * `SOQPSK_INTERP;

   logic      clk;
   logic      reset;
   logic      dataBit;
   symbol_t   expSym;
   logic      symEn;
   symbol_t   symOut;
   freqWord_t freqOut;

   logic [3:0] patMem [0:2*NUM_PAT-1];   // Bit and symbol code, interleaved.
   logic       patBit [NUM_PAT];
   symbol_t    patSym [NUM_PAT];

   int resetErrs;
   int strobeErrs;
   int symErrs;
   int shapeErrs;
   int runErrs;
   int timeouts;
   int total;

   soqpskFreqPulse DUT (
      .clk     (clk),
      .reset   (reset),
      .dataBit (dataBit),
      .symEn   (symEn),
      .symOut  (symOut),
      .freqOut (freqOut)
   );

   freqPulseChecker uChecker (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .symOut     (symOut),
      .freqOut    (freqOut),
      .expSym     (expSym),
      .resetErrs  (resetErrs),
      .strobeErrs (strobeErrs),
      .symErrs    (symErrs),
      .shapeErrs  (shapeErrs),
      .runErrs    (runErrs)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Symbol code as stored in the pattern file, -1 is 3 in two bits.
   function automatic symbol_t decodeSym(input logic [3:0] code);
      case (code)
         4'h1:    return symPlus;
         4'h3:    return symMinus;
         default: return symZero;
      endcase
   endfunction

   // Returns just after the edge that raised symEn, or gives up.
   task automatic waitForStrobe(output logic timedOut);
      int waited;
      waited   = 0;
      timedOut = 1'b1;
      while (waited < STROBE_TIMEOUT) begin
         @(posedge clk);
         #DRIVE_DELAY;
         waited++;
         if (symEn) begin
            timedOut = 1'b0;
            break;
         end
      end
      if (timedOut) begin
         $display("symEn never asserted within %0d clocks", STROBE_TIMEOUT);
      end
   endtask

   // ======================================================================
   // Stimulus
   // ======================================================================
   initial begin
      logic timedOut;
      reset    = 1'b1;
      dataBit  = 1'b0;
      expSym   = symZero;
      timedOut = 1'b0;
      timeouts = 0;
      $readmemh("verif/soqpsk_patterns.txt", patMem);
      for (int i = 0; i < NUM_PAT; i++) begin
         patBit[i] = patMem[2*i][0];
         patSym[i] = decodeSym(patMem[2*i+1]);
      end

      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      for (int i = 0; i < NUM_PAT && !timedOut; i++) begin
         waitForStrobe(timedOut);
         if (!timedOut) begin
            dataBit = patBit[i];
            expSym  = patSym[i];   // Checker takes it on the same strobe.
         end
      end
      if (!timedOut) waitForStrobe(timedOut);   // Lets the last symbol play out.
      if (timedOut) timeouts++;

      total = resetErrs + strobeErrs + symErrs + shapeErrs + runErrs + timeouts;
      $display("errors: reset %0d strobe %0d symbol %0d shape %0d run %0d timeout %0d",
               resetErrs, strobeErrs, symErrs, shapeErrs, runErrs, timeouts);
      if (total == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* verif/soqpsk_patterns.txt */
// Columns: input bit, expected symbol (0 is zero, 1 is +1, 3 is -1 in two bits).
// Mixed start, run of ones, nonzero run of +1, nonzero run of -1, run of ones.
1 0
0 3
0 3
1 3
0 0
1 0
1 3
0 3
1 0
1 1
1 0
1 0
1 0
1 0
1 0
1 0
0 1
0 1
1 1
1 1
0 1
0 1
1 1
1 1
1 0
0 3
0 3
1 3
1 3
1 0
1 0
1 0
1 0
1 0

/* verilog.f */
+incdir+include
hw/soqpskPkg.sv
hw/dspPkg.sv
hw/symbolTimer.sv
hw/soqpskPrecoder.sv
hw/cicInterpolate.sv
hw/freqScaler.sv
hw/soqpskFreqPulse.sv
verif/freqPulseChecker.sv
verif/tbSoqpskFreqPulse.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbSoqpskFreqPulse
RTL_TOP   ?= soqpskFreqPulse
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= hw/soqpskPkg.sv hw/dspPkg.sv hw/symbolTimer.sv hw/soqpskPrecoder.sv \
             hw/cicInterpolate.sv hw/freqScaler.sv hw/soqpskFreqPulse.sv
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+include --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
